/* sim.f */
+incdir+dv
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_branch_unit.sv
source/rv_regfile.sv
source/rv_core.sv
dv/rv_core_assert.sv
dv/rv_core_tb.sv

/* dv/rv_core_program.svh */
`ifndef RV_CORE_PROGRAM_SVH
`define RV_CORE_PROGRAM_SVH

// One row per instruction word, indexed by pc / 4
typedef struct packed {
    word_t     instr;   // Instruction word at this address
    logic      wr;      // Expected rd_wr_en
    reg_addr_t rd;      // Expected rd_addr
    word_t     data;    // Expected rd_data
    word_t     npc;     // Expected next_pc
} row_t;

localparam int    NUM_ROWS = 48;
localparam word_t SKIP     = 32'hFFF00F93;   // addi x31, x0, -1, never reached

// Columns: instr, wr, rd, data, npc
function automatic row_t program_row(input int idx);
    row_t r;
    case (idx)
        0:  r = '{32'h00500093, 1'b1, 5'd1,  32'h00000005, 32'd4};    // addi x1, x0, 5
        1:  r = '{32'hFFD00113, 1'b1, 5'd2,  32'hFFFFFFFD, 32'd8};    // addi x2, x0, -3
        2:  r = '{32'h00112193, 1'b1, 5'd3,  32'h00000001, 32'd12};   // slti x3, x2, 1
        3:  r = '{32'h00113213, 1'b1, 5'd4,  32'h00000000, 32'd16};   // sltiu x4, x2, 1
        4:  r = '{32'h0F00C293, 1'b1, 5'd5,  32'h000000F5, 32'd20};   // xori x5, x1, 0xf0
        5:  r = '{32'h1000E313, 1'b1, 5'd6,  32'h00000105, 32'd24};   // ori x6, x1, 0x100
        6:  r = '{32'h0FF17393, 1'b1, 5'd7,  32'h000000FD, 32'd28};   // andi x7, x2, 0xff
        7:  r = '{32'h00409413, 1'b1, 5'd8,  32'h00000050, 32'd32};   // slli x8, x1, 4
        8:  r = '{32'h01C15493, 1'b1, 5'd9,  32'h0000000F, 32'd36};   // srli x9, x2, 28
        9:  r = '{32'h40115513, 1'b1, 5'd10, 32'hFFFFFFFE, 32'd40};   // srai x10, x2, 1
        10: r = '{32'h002085B3, 1'b1, 5'd11, 32'h00000002, 32'd44};   // add x11, x1, x2
        11: r = '{32'h40208633, 1'b1, 5'd12, 32'h00000008, 32'd48};   // sub x12, x1, x2
        12: r = '{32'h00B096B3, 1'b1, 5'd13, 32'h00000014, 32'd52};   // sll x13, x1, x11
        13: r = '{32'h00112733, 1'b1, 5'd14, 32'h00000001, 32'd56};   // slt x14, x2, x1
        14: r = '{32'h001137B3, 1'b1, 5'd15, 32'h00000000, 32'd60};   // sltu x15, x2, x1
        15: r = '{32'h0020C833, 1'b1, 5'd16, 32'hFFFFFFF8, 32'd64};   // xor x16, x1, x2
        16: r = '{32'h00B158B3, 1'b1, 5'd17, 32'h3FFFFFFF, 32'd68};   // srl x17, x2, x11
        17: r = '{32'h40B15933, 1'b1, 5'd18, 32'hFFFFFFFF, 32'd72};   // sra x18, x2, x11
        18: r = '{32'h00B0E9B3, 1'b1, 5'd19, 32'h00000007, 32'd76};   // or x19, x1, x11
        19: r = '{32'h00617A33, 1'b1, 5'd20, 32'h00000105, 32'd80};   // and x20, x2, x6
        // Each condition not taken, then taken over one skipped word
        20: r = '{32'h00B08463, 1'b0, 5'd0,  32'h00000000, 32'd84};   // beq x1, x11
        21: r = '{32'h00108463, 1'b0, 5'd0,  32'h00000000, 32'd92};   // beq x1, x1
        22: r = '{SKIP,         1'b1, 5'd31, 32'hFFFFFFFF, 32'd92};
        23: r = '{32'h00109463, 1'b0, 5'd0,  32'h00000000, 32'd96};   // bne x1, x1
        24: r = '{32'h00B09463, 1'b0, 5'd0,  32'h00000000, 32'd104};  // bne x1, x11
        25: r = '{SKIP,         1'b1, 5'd31, 32'hFFFFFFFF, 32'd104};
        26: r = '{32'h0020C463, 1'b0, 5'd0,  32'h00000000, 32'd108};  // blt x1, x2
        27: r = '{32'h00114463, 1'b0, 5'd0,  32'h00000000, 32'd116};  // blt x2, x1
        28: r = '{SKIP,         1'b1, 5'd31, 32'hFFFFFFFF, 32'd116};
        29: r = '{32'h00115463, 1'b0, 5'd0,  32'h00000000, 32'd120};  // bge x2, x1
        30: r = '{32'h0020D463, 1'b0, 5'd0,  32'h00000000, 32'd128};  // bge x1, x2
        31: r = '{SKIP,         1'b1, 5'd31, 32'hFFFFFFFF, 32'd128};
        32: r = '{32'h00116463, 1'b0, 5'd0,  32'h00000000, 32'd132};  // bltu x2, x1
        33: r = '{32'h0020E463, 1'b0, 5'd0,  32'h00000000, 32'd140};  // bltu x1, x2
        34: r = '{SKIP,         1'b1, 5'd31, 32'hFFFFFFFF, 32'd140};
        35: r = '{32'h0020F463, 1'b0, 5'd0,  32'h00000000, 32'd144};  // bgeu x1, x2
        36: r = '{32'h00117463, 1'b0, 5'd0,  32'h00000000, 32'd152};  // bgeu x2, x1
        37: r = '{SKIP,         1'b1, 5'd31, 32'hFFFFFFFF, 32'd152};
        38: r = '{32'h00708013, 1'b1, 5'd0,  32'h0000000C, 32'd156};  // addi x0, x1, 7
        39: r = '{32'h00100AB3, 1'b1, 5'd21, 32'h00000005, 32'd160};  // add x21, x0, x1
        40: r = '{32'h12345B37, 1'b1, 5'd22, 32'h12345000, 32'd164};  // lui x22, 0x12345
        41: r = '{32'h00001B97, 1'b1, 5'd23, 32'h000010A4, 32'd168};  // auipc x23, 1
        42: r = '{32'h00C00C6F, 1'b1, 5'd24, 32'h000000AC, 32'd180};  // jal x24, +12
        43: r = '{SKIP,         1'b1, 5'd31, 32'hFFFFFFFF, 32'd176};
        44: r = '{SKIP,         1'b1, 5'd31, 32'hFFFFFFFF, 32'd180};
        45: r = '{32'h011C0CE7, 1'b1, 5'd25, 32'h000000B8, 32'd188};  // jalr x25, 17(x24)
        46: r = '{SKIP,         1'b1, 5'd31, 32'hFFFFFFFF, 32'd188};
        47: r = '{32'h019C0D33, 1'b1, 5'd26, 32'h00000164, 32'd192};  // add x26, x24, x25
        default: r = '{32'h00000013, 1'b0, 5'd0, 32'h00000000, 32'h00000000};  // nop
    endcase
    return r;
endfunction

`endif

/* dv/rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb;
    import rv_pkg::*;

    `include "rv_core_program.svh"

    localparam int    CLK_PERIOD       = 20;
    localparam int    RESET_CYCLES     = 10;
    localparam int    CYCLES_PER_INSTR = 4;
    localparam word_t RESET_PC         = '0;
    localparam word_t LAST_PC          = word_t'((NUM_ROWS - 1) * 4);   // Final row ends the run
    localparam int    WATCHDOG_NS      = (NUM_ROWS + 4) * CYCLES_PER_INSTR * CLK_PERIOD;

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    logic      retire_valid;
    word_t     retire_pc;
    word_t     next_pc;
    logic      rd_wr_en;
    reg_addr_t rd_addr;
    word_t     rd_data;
    row_t      fetch_row;

    rv_core #(
        .NUM_REGS (32)
    ) rv_core_inst (
        .clk          (clk),
        .reset        (reset),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .next_pc      (next_pc),
        .rd_wr_en     (rd_wr_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Asynchronous word-addressed instruction memory
    always_comb begin
        fetch_row = program_row(int'(imem_addr >> 2));
    end
    assign imem_data = fetch_row.instr;

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("[ERROR] %s: expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t expected,
                                  input reg_addr_t actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("[ERROR] %s: expected %0d, actual %0d",
                                      name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("[ERROR] %s: expected %b, actual %b",
                                      name, expected, actual));
        end
    endtask

    // Samples at the falling edge mid-cycle
    task automatic wait_for_retire();
        do begin
            @(negedge clk);
            if (rv_core_inst.u_assert.error_count != 0) begin
                stop_on_failure("A bound assertion on the core reported a violation");
            end
        end while (retire_valid !== 1'b1);
    endtask

    initial begin
        row_t  row;
        word_t expect_pc;
        int    idx;
        string tag;
        logic  done;
        clk   = 1'b0;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        expect_pc = RESET_PC;
        done      = 1'b0;
        while (!done) begin
            wait_for_retire();
            idx = int'(retire_pc >> 2);
            tag = $sformatf("row %0d", idx);
            check_word({tag, " retire_pc"}, expect_pc, retire_pc);   // Follows the taken path
            row = program_row(idx);
            check_flag({tag, " rd_wr_en"}, row.wr, rd_wr_en);
            if (row.wr) begin
                check_reg_addr({tag, " rd_addr"}, row.rd, rd_addr);
                check_word({tag, " rd_data"}, row.data, rd_data);
            end
            check_word({tag, " next_pc"}, row.npc, next_pc);
            expect_pc = row.npc;
            done      = retire_pc == LAST_PC;
        end
        if (rv_core_inst.u_assert.error_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_on_failure("A bound assertion on the core reported a violation");
        end
    end

    // Watchdog starts when reset drops
    initial begin
        wait (reset === 1'b0);
        #(WATCHDOG_NS);
        stop_on_failure("Timeout: retirement stalled before the last program row");
    end

endmodule

/* dv/rv_core_assert.sv */
`timescale 1ns/100ps

module rv_core_assert (
    input logic          clk,
    input logic          reset,
    input rv_pkg::word_t imem_addr,
    input logic          retire_valid,
    input logic          rd_wr_en
);
    int error_count = 0;   // Read by the testbench

    // One retire every fourth cycle, never closer
    assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> !retire_valid ##1 !retire_valid ##1 !retire_valid ##1 retire_valid)
        else begin
            $error("retire_valid not spaced four cycles apart");
            error_count++;
        end

    assert property (@(posedge clk) disable iff (reset) rd_wr_en |-> retire_valid)
        else begin
            $error("rd_wr_en high outside a retire cycle");
            error_count++;
        end

    assert property (@(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00)
        else begin
            $error("imem_addr not word aligned");
            error_count++;
        end

    // State is back in FETCH one edge into reset
    assert property (@(posedge clk) reset |=> !retire_valid)
        else begin
            $error("retire_valid high during reset");
            error_count++;
        end

endmodule

bind rv_core rv_core_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .imem_addr    (imem_addr),
    .retire_valid (retire_valid),
    .rd_wr_en     (rd_wr_en)
);

/* source/rv_core.sv */
`timescale 1ns/100ps

module rv_core #(
    parameter int NUM_REGS = 32
) (
    input  logic              clk,
    input  logic              reset,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output logic              retire_valid,
    output rv_pkg::word_t     retire_pc,
    output rv_pkg::word_t     next_pc,
    output logic              rd_wr_en,
    output rv_pkg::reg_addr_t rd_addr,
    output rv_pkg::word_t     rd_data
);
    import rv_pkg::*;

    typedef enum logic [1:0] {FETCH, DECODE, EXECUTE, WRITEBACK} state_t;

    localparam word_t FOUR = word_t'(4);

    state_t state;
    word_t  pc;
    word_t  pc_plus4;
    word_t  ir;   // Instruction register

    // Decoder outputs
    opcode_t    opcode;
    reg_addr_t  rs1_addr, rs2_addr;
    logic [2:0] funct3;
    word_t      imm;
    alu_op_t    alu_op;
    src_a_t     src_a;
    src_b_t     src_b;
    logic       writes_rd;

    word_t rs1_data, rs2_data;   // Register file reads
    word_t rs1_q, rs2_q;         // Operands held from DECODE
    word_t alu_a, alu_b, alu_result;
    logic  br_taken;
    word_t br_target;
    word_t alu_q;                // Results held from EXECUTE
    logic  taken_q;
    word_t target_q;

    rv_decoder u_decoder (
        .instr     (ir),
        .opcode    (opcode),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rd_addr   (rd_addr),
        .funct3    (funct3),
        .imm       (imm),
        .alu_op    (alu_op),
        .src_a     (src_a),
        .src_b     (src_b),
        .writes_rd (writes_rd)
    );

    rv_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (rd_wr_en),   // Lands at the edge ending WRITEBACK
        .wr_addr  (rd_addr),
        .wr_data  (rd_data)
    );

    // Operand muxes
    assign alu_a = (src_a == SRC_A_PC) ? pc : rs1_q;

    always_comb begin
        case (src_b)
            SRC_B_RS2:  alu_b = rs2_q;
            SRC_B_IMM:  alu_b = imm;
            SRC_B_FOUR: alu_b = FOUR;
            default:    alu_b = '0;
        endcase
    end

    rv_alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // Sees the same operands as the ALU side by side
    rv_branch_unit u_branch (
        .opcode (opcode),
        .funct3 (funct3),
        .rs1    (rs1_q),
        .rs2    (rs2_q),
        .pc     (pc),
        .imm    (imm),
        .taken  (br_taken),
        .target (br_target)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;   // Fetch starts right after reset drops
            pc    <= '0;
        end else begin
            case (state)
                FETCH:   state <= DECODE;
                DECODE:  state <= EXECUTE;
                EXECUTE: state <= WRITEBACK;
                default: begin
                    state <= FETCH;
                    pc    <= next_pc;   // Commit with the register write
                end
            endcase
        end
    end

    // Stage payload registers
    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            ir <= imem_data;   // Async imem sampled at end of FETCH
        end
        if (state == DECODE) begin
            rs1_q <= rs1_data;
            rs2_q <= rs2_data;
        end
        if (state == EXECUTE) begin
            alu_q    <= alu_result;
            taken_q  <= br_taken;
            target_q <= br_target;
        end
    end

    assign imem_addr = pc;
    assign pc_plus4  = pc + FOUR;
    assign next_pc   = taken_q ? target_q : pc_plus4;

    // Writeback data select
    always_comb begin
        case (opcode)
            OPC_LUI: rd_data = imm;
            default: rd_data = alu_q;   // ALU sum or PC+4 for jumps
        endcase
    end

    // One retire pulse per instruction
    assign retire_valid = state == WRITEBACK;
    assign retire_pc    = pc;
    assign rd_wr_en     = retire_valid && writes_rd;

endmodule

/* source/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic              clk,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              wr_en,
    input  rv_pkg::reg_addr_t wr_addr,
    input  rv_pkg::word_t     wr_data
);
    import rv_pkg::*;

    word_t regs [NUM_REGS];

    // x0 and indexes past NUM_REGS read as zero
    assign rs1_data = (rs1_addr != '0 && int'(rs1_addr) < NUM_REGS) ? regs[rs1_addr] : '0;
    assign rs2_data = (rs2_addr != '0 && int'(rs2_addr) < NUM_REGS) ? regs[rs2_addr] : '0;

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0 && int'(wr_addr) < NUM_REGS) begin
            regs[wr_addr] <= wr_data;   // x0 writes dropped
        end
    end

endmodule

/* source/rv_branch_unit.sv */
`timescale 1ns/100ps

module rv_branch_unit (
    input  rv_pkg::opcode_t opcode,
    input  logic [2:0]      funct3,
    input  rv_pkg::word_t   rs1,
    input  rv_pkg::word_t   rs2,
    input  rv_pkg::word_t   pc,
    input  rv_pkg::word_t   imm,
    output logic            taken,
    output rv_pkg::word_t   target
);
    import rv_pkg::*;

    branch_kind_t kind;
    logic         eq, lt, ltu;
    logic         cond;   // Branch condition met
    word_t        jalr_sum;

    assign kind = branch_kind_t'(funct3);
    assign eq   = rs1 == rs2;
    assign lt   = $signed(rs1) < $signed(rs2);
    assign ltu  = rs1 < rs2;

    always_comb begin
        case (kind)
            BR_EQ:   cond = eq;
            BR_NE:   cond = !eq;
            BR_LT:   cond = lt;
            BR_GE:   cond = !lt;
            BR_LTU:  cond = ltu;
            BR_GEU:  cond = !ltu;
            default: cond = 1'b0;   // Reserved funct3
        endcase
    end

    // Jumps always taken
    assign taken = (opcode == OPC_BRANCH && cond) || opcode == OPC_JAL || opcode == OPC_JALR;

    assign jalr_sum = rs1 + imm;
    assign target   = (opcode == OPC_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;

endmodule

/* source/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];   // Only low five bits count
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};   // 0 or 1
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);  // Sign fill
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

/* source/rv_decoder.sv */
`timescale 1ns/100ps

module rv_decoder (
    input  rv_pkg::word_t     instr,
    output rv_pkg::opcode_t   opcode,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::reg_addr_t rd_addr,
    output logic [2:0]        funct3,
    output rv_pkg::word_t     imm,
    output rv_pkg::alu_op_t   alu_op,
    output rv_pkg::src_a_t    src_a,
    output rv_pkg::src_b_t    src_b,
    output logic              writes_rd
);
    import rv_pkg::*;

    word_t imm_i, imm_b, imm_j, imm_u;
    logic  alt;   // funct7[5], also bit 30 for immediate shifts

    // Map funct3 to an ALU operation
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt_bit,
                                         input logic is_reg);
        alu_op_t op;
        case (f3)
            3'b000:  op = (is_reg && alt_bit) ? ALU_SUB : ALU_ADD; // No SUBI
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode   = opcode_t'(instr[6:0]);
    assign rd_addr  = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign alt      = instr[30];

    // Sign-extended immediates per format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};   // Low bits zero

    always_comb begin
        imm       = '0;
        alu_op    = ALU_ADD;
        src_a     = SRC_A_RS1;
        src_b     = SRC_B_IMM;
        writes_rd = 1'b0;   // Unknown opcodes retire without a write
        case (opcode)
            OPC_OP: begin
                src_b     = SRC_B_RS2;
                alu_op    = arith_op(funct3, alt, 1'b1);
                writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                imm       = imm_i;
                alu_op    = arith_op(funct3, alt, 1'b0);
                writes_rd = 1'b1;
            end
            OPC_BRANCH: begin
                imm    = imm_b;
                src_b  = SRC_B_RS2;
                alu_op = ALU_SUB;   // Result unused, compare lives in branch unit
            end
            OPC_JAL, OPC_JALR: begin
                imm       = (opcode == OPC_JAL) ? imm_j : imm_i;
                src_a     = SRC_A_PC;   // ALU makes return address
                src_b     = SRC_B_FOUR;
                writes_rd = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                imm       = imm_u;
                src_a     = SRC_A_PC;   // PC + imm for AUIPC
                writes_rd = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

    // Datapath width, fixed for RV32I
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;   // Data, address or instruction
    typedef logic [4:0]      reg_addr_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // Register-register ALU
        OPC_OP_IMM = 7'b0010011,  // Register-immediate ALU
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // Branch condition, taken straight from funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_kind_t;

    typedef enum logic {
        SRC_A_PC,
        SRC_A_RS1
    } src_a_t;

    typedef enum logic [1:0] {
        SRC_B_RS2,
        SRC_B_IMM,
        SRC_B_FOUR   // Constant 4 for return address
    } src_b_t;

endpackage
